/* huff_defs.svh */
// huff decoder defines: symbol, code, window and fill widths shared by the datapath
`ifndef HUFF_DEFS_SVH
`define HUFF_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// symbol and stream widths
//////////////////////////////////////////////////////////////////////
`define HUFF_SYM_W      8   // decoded symbol, conf field and stream byte

//////////////////////////////////////////////////////////////////////
// supported code widths
//////////////////////////////////////////////////////////////////////
`define HUFF_MIN_CODE_W 2   // shortest code
`define HUFF_MAX_CODE_W 5   // longest code, also width of the window head

//////////////////////////////////////////////////////////////////////
// bit window
//////////////////////////////////////////////////////////////////////
`define HUFF_WIN_W      16  // two bytes of coded bits
`define HUFF_FILL_W     5   // counts 0 to 16 valid bits

`endif

/* huff_pkg.sv */
// huff package: data types shared between the bit window, code groups and matcher
`default_nettype none
`include "huff_defs.svh"

package huff_pkg;

  // one decoded symbol, same shape as d_conf, d_in and d_out
  typedef logic [`HUFF_SYM_W-1:0] sym_t;

  // configuration field
  // h_conf carries the code right aligned, w_conf the code width
  typedef logic [`HUFF_SYM_W-1:0] conf_t;

  // oldest bits of the window, msb is the next bit on the line
  typedef logic [`HUFF_MAX_CODE_W-1:0] head_t;

  // number of valid bits held in the window
  typedef logic [`HUFF_FILL_W-1:0] fill_t;

  // matched code length, 0 means nothing matched this cycle
  typedef logic [$clog2(`HUFF_MAX_CODE_W+1)-1:0] len_t;

endpackage

`default_nettype wire

/* huff_code_group.sv */
// huff code group: valid bits and symbol table for all codes of one width
`timescale 1ns/1ps
`default_nettype none
`include "huff_defs.svh"

module huff_code_group #(
  parameter int CODE_W = 2  // code width served by this group
) (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            en_conf,  // table write strobe
  input  wire logic            new_conf, // clear all entries
  input  wire huff_pkg::sym_t  d_conf,   // symbol to store
  input  wire huff_pkg::conf_t h_conf,   // code, right aligned
  input  wire huff_pkg::conf_t w_conf,   // code width of this write
  input  wire huff_pkg::head_t head,     // window head, msb first
  input  wire huff_pkg::fill_t fill,     // valid bits in the window
  output logic                 hit,      // full code of this width at the head
  output huff_pkg::sym_t       sym       // symbol for the head code
);

  localparam int DEPTH = 1 << CODE_W;  // one entry per code value

  // width outside the supported range is a build error
  if (CODE_W < `HUFF_MIN_CODE_W || CODE_W > `HUFF_MAX_CODE_W) begin : g_bad_width
    $error("huff_code_group: CODE_W %0d not supported", CODE_W);
  end

  logic [DEPTH-1:0] valid_q;            // entry present
  huff_pkg::sym_t   sym_mem [DEPTH];    // symbol per code
  logic             wr_en;
  logic [CODE_W-1:0] wr_idx;
  logic [CODE_W-1:0] rd_idx;

  //////////////////////////////////////////////////////////////////////
  // configuration write
  //////////////////////////////////////////////////////////////////////

  // each group takes only the writes of its own width
  assign wr_en  = en_conf && (w_conf == huff_pkg::conf_t'(CODE_W));
  assign wr_idx = h_conf[CODE_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (new_conf) begin
      valid_q <= '0;              // wins over a same cycle write
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      sym_mem[wr_idx] <= d_conf;  // stale symbols are masked by valid_q
    end
  end

  //////////////////////////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////////////////////////

  assign rd_idx = head[`HUFF_MAX_CODE_W-1 -: CODE_W];  // leading bits only

  // short window must not match on bits not yet fetched
  assign hit = valid_q[rd_idx] && (fill >= huff_pkg::fill_t'(CODE_W));
  assign sym = sym_mem[rd_idx];

endmodule

`default_nettype wire

/* huff_code_matcher.sv */
// huff code matcher: one code group per width, match select and registered symbol output
`timescale 1ns/1ps
`default_nettype none
`include "huff_defs.svh"

module huff_code_matcher (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            en_conf,
  input  wire logic            new_conf,
  input  wire huff_pkg::sym_t  d_conf,
  input  wire huff_pkg::conf_t h_conf,
  input  wire huff_pkg::conf_t w_conf,
  input  wire huff_pkg::head_t head,
  input  wire huff_pkg::fill_t fill,
  output huff_pkg::len_t       match_len, // bits to drop, 0 when no match
  output huff_pkg::sym_t       d_out,     // decoded symbol
  output logic                 en_out     // one pulse per symbol
);

  localparam int MIN_W = `HUFF_MIN_CODE_W;
  localparam int MAX_W = `HUFF_MAX_CODE_W;

  logic [MAX_W:MIN_W] grp_hit;             // indexed by code width
  huff_pkg::sym_t     grp_sym [MIN_W:MAX_W];
  huff_pkg::sym_t     sel_sym;
  logic               any_hit;

  //////////////////////////////////////////////////////////////////////
  // code groups, widths 2 to 5
  //////////////////////////////////////////////////////////////////////

  for (genvar w = MIN_W; w <= MAX_W; w++) begin : g_grp
    huff_code_group #(
      .CODE_W   (w)
    ) grp_i (
      .clk      (clk),
      .rst      (rst),
      .en_conf  (en_conf),
      .new_conf (new_conf),
      .d_conf   (d_conf),
      .h_conf   (h_conf),
      .w_conf   (w_conf),
      .head     (head),
      .fill     (fill),
      .hit      (grp_hit[w]),
      .sym      (grp_sym[w])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // select
  //////////////////////////////////////////////////////////////////////

  // walk from the widest down so the shortest hit is the one kept
  always_comb begin
    match_len = '0;
    sel_sym   = '0;
    for (int w = MAX_W; w >= MIN_W; w--) begin
      if (grp_hit[w]) begin
        match_len = huff_pkg::len_t'(w);
        sel_sym   = grp_sym[w];
      end
    end
  end

  assign any_hit = |grp_hit;

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      en_out <= 1'b0;
    end else begin
      en_out <= any_hit;   // one cycle after the code stands at the head
    end
  end

  always_ff @(posedge clk) begin
    if (any_hit) begin
      d_out <= sel_sym;    // held between symbols
    end
  end

  // prefix free table, so two widths never claim the same head
  a_one_group: assert property (
    @(posedge clk) disable iff (rst) $onehot0(grp_hit)
  ) else $error("huff_code_matcher: more than one group hit");

endmodule

`default_nettype wire

/* huff_bit_window.sv */
// huff bit window: requests stream bytes, keeps a left aligned bit window and drops used bits
`timescale 1ns/1ps
`default_nettype none
`include "huff_defs.svh"

module huff_bit_window (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            ready_in,  // source still has bytes
  input  wire logic            en_in,     // byte strobe, answers one d_req
  input  wire huff_pkg::sym_t  d_in,      // coded byte, msb first
  input  wire huff_pkg::len_t  match_len, // bits used by this cycle's match
  output logic                 d_req,     // one cycle byte request
  output huff_pkg::head_t      head,      // oldest bits of the window
  output huff_pkg::fill_t      fill       // valid bit count
);

  localparam int WIN_W  = `HUFF_WIN_W;
  localparam int BYTE_W = `HUFF_SYM_W;
  localparam int HEAD_W = `HUFF_MAX_CODE_W;

  //////////////////////////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////////////////////////

  logic [WIN_W-1:0] win_q;   // bit WIN_W-1 is the oldest bit
  huff_pkg::fill_t  fill_q;  // valid bits from the top of win_q
  logic             pend_q;  // a request is out and unanswered

  //////////////////////////////////////////////////////////////////////
  // next window
  //////////////////////////////////////////////////////////////////////

  logic [WIN_W-1:0] byte_al;   // arriving byte at the top of a window
  logic [WIN_W-1:0] win_kept;  // window after the match is dropped
  logic [WIN_W-1:0] win_new;
  huff_pkg::fill_t  fill_kept;
  huff_pkg::fill_t  fill_new;
  logic             req_ok;    // fetch condition for this cycle

  assign byte_al = {d_in, {(WIN_W-BYTE_W){1'b0}}};

  always_comb begin
    // drop the matched code first
    win_kept  = win_q << match_len;  // zeros come in behind the valid bits
    fill_kept = fill_q - huff_pkg::fill_t'(match_len);
    win_new   = win_kept;
    fill_new  = fill_kept;
    // then append the byte right behind what is left
    if (en_in) begin
      win_new  = win_kept | (byte_al >> fill_kept);
      fill_new = fill_kept + huff_pkg::fill_t'(BYTE_W);
    end
  end

  // room for a whole byte once this cycle's bits are gone
  assign req_ok = ready_in && !pend_q &&
                  (fill_kept <= huff_pkg::fill_t'(WIN_W - BYTE_W));

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  // bits below the fill stay zero, so the window needs a clear start
  always_ff @(posedge clk) begin
    if (rst) begin
      win_q  <= '0;
      fill_q <= '0;
    end else begin
      win_q  <= win_new;
      fill_q <= fill_new;
    end
  end

  // request flag and strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      pend_q <= 1'b0;
      d_req  <= 1'b0;
    end else begin
      d_req <= req_ok;      // single pulse, pend_q blocks the next one
      if (req_ok) begin
        pend_q <= 1'b1;     // opened together with the strobe
      end else if (en_in) begin
        pend_q <= 1'b0;     // byte is in, next fetch may go
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  assign head = win_q[WIN_W-1 -: HEAD_W];
  assign fill = fill_q;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // the source sends a byte only against an open request
  a_byte_requested: assert property (
    @(posedge clk) disable iff (rst) en_in |-> pend_q
  ) else $error("huff_bit_window: byte without an open request");

  // the matcher never takes more bits than the window holds
  a_match_in_fill: assert property (
    @(posedge clk) disable iff (rst)
    huff_pkg::fill_t'(match_len) <= fill_q
  ) else $error("huff_bit_window: match longer than fill");

  // fetch timing keeps the window from overflowing
  a_fill_bound: assert property (
    @(posedge clk) disable iff (rst)
    fill_q <= huff_pkg::fill_t'(WIN_W)
  ) else $error("huff_bit_window: fill above window width");

endmodule

`default_nettype wire

/* huff_decoder.sv */
// huff decoder top: streaming huffman decoder for 8 bit symbols, codes of 2 to 5 bits
`timescale 1ns/1ps
`default_nettype none

module huff_decoder (
  input  wire logic            clk,
  input  wire logic            rst,
  // stream side
  input  wire logic            ready_in,  // source not empty
  input  wire logic            en_in,     // byte strobe
  input  wire huff_pkg::sym_t  d_in,      // coded byte
  output wire logic            d_req,     // byte request
  // configuration side, only while the stream is idle
  input  wire huff_pkg::sym_t  d_conf,    // symbol
  input  wire huff_pkg::conf_t h_conf,    // code, right aligned
  input  wire huff_pkg::conf_t w_conf,    // code width
  input  wire logic            en_conf,   // write one entry
  input  wire logic            new_conf,  // drop the whole table
  // decoded output, no back-pressure
  output wire huff_pkg::sym_t  d_out,
  output wire logic            en_out
);

  wire huff_pkg::head_t head;       // window head to the groups
  wire huff_pkg::fill_t fill;       // valid bit count
  wire huff_pkg::len_t  match_len;  // bits consumed at the next edge

  // byte fetch and bit window
  huff_bit_window win_i (
    .clk       (clk),
    .rst       (rst),
    .ready_in  (ready_in),
    .en_in     (en_in),
    .d_in      (d_in),
    .match_len (match_len),
    .d_req     (d_req),
    .head      (head),
    .fill      (fill)
  );

  // code tables and symbol output
  huff_code_matcher match_i (
    .clk       (clk),
    .rst       (rst),
    .en_conf   (en_conf),
    .new_conf  (new_conf),
    .d_conf    (d_conf),
    .h_conf    (h_conf),
    .w_conf    (w_conf),
    .head      (head),
    .fill      (fill),
    .match_len (match_len),
    .d_out     (d_out),
    .en_out    (en_out)
  );

endmodule

`default_nettype wire

/* tb_huff_decoder.sv */
// huff decoder testbench: table loads, coded byte streams from a source model, reference compare
`timescale 1ns/1ps
`default_nettype none
`include "huff_defs.svh"

module tb_huff_decoder;

  localparam int MIN_W = `HUFF_MIN_CODE_W;
  localparam int MAX_W = `HUFF_MAX_CODE_W;
  // worst case stream length, every symbol at the widest code plus padding
  localparam int MAX_BYTES   = ((200 + 200 + 100) * MAX_W + 3 * 7) / 8 + 4;
  localparam int CYCLE_LIMIT = 40 * MAX_BYTES + 2000;

  logic             clk;
  logic             rst;
  logic             ready_in;
  logic             en_in;
  huff_pkg::sym_t   d_in;
  logic             d_req;
  huff_pkg::sym_t   d_conf;
  huff_pkg::conf_t  h_conf;
  huff_pkg::conf_t  w_conf;
  logic             en_conf;
  logic             new_conf;
  huff_pkg::sym_t   d_out;
  logic             en_out;

  int unsigned      lcg_state = 32'd14530;
  int               err_cnt   = 0;
  int               check_cnt = 0;
  int               req_cnt   = 0;
  int               cycle_cnt = 0;
  logic             pause_on  = 1'b0;  // random ready_in drops
  logic [7:0]       src_q [$];         // bytes still held by the source
  huff_pkg::sym_t   exp_q [$];         // symbols still to come out
  // loaded table, as entries and as a lookup copy
  huff_pkg::sym_t   tab_sym  [16];
  logic [4:0]       tab_code [16];
  int               tab_w    [16];
  int               tab_n;
  logic             ref_valid [MIN_W:MAX_W][32];
  huff_pkg::sym_t   ref_sym   [MIN_W:MAX_W][32];

  huff_decoder dut_i (
    .clk      (clk),
    .rst      (rst),
    .ready_in (ready_in),
    .en_in    (en_in),
    .d_in     (d_in),
    .d_req    (d_req),
    .d_conf   (d_conf),
    .h_conf   (h_conf),
    .w_conf   (w_conf),
    .en_conf  (en_conf),
    .new_conf (new_conf),
    .d_out    (d_out),
    .en_out   (en_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) & 32'h7fff;  // upper bits, better spread
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;  // inputs move just after the edge
  endtask

  function automatic void clear_ref();
    int w;
    int c;
    for (w = MIN_W; w <= MAX_W; w++) begin
      for (c = 0; c < 32; c++) begin
        ref_valid[w][c] = 1'b0;
      end
    end
  endfunction

  function automatic void add_entry(input logic [7:0] sym, input logic [4:0] code, input int w);
    tab_sym[tab_n]  = sym;
    tab_code[tab_n] = code;
    tab_w[tab_n]    = w;
    tab_n++;
  endfunction

  // expected symbols, prefix match with the shortest width tried first
  function automatic void ref_decode(input bit bits[$]);
    int   pos;
    int   w;
    int   b;
    int   code;
    logic found;
    pos   = 0;
    found = 1'b1;
    while (found) begin
      found = 1'b0;
      for (w = MIN_W; w <= MAX_W && !found; w++) begin
        if (pos + w <= bits.size()) begin
          code = 0;
          for (b = 0; b < w; b++) begin
            code = (code << 1) | bits[pos + b];
          end
          if (ref_valid[w][code]) begin
            exp_q.push_back(ref_sym[w][code]);
            pos   = pos + w;
            found = 1'b1;
          end
        end
      end
    end
  endfunction

  // random symbols into source bytes, tail padded with bits of one more code
  function automatic void encode_stream(input int n_sym);
    bit         bits_q [$];
    int         i;
    int         b;
    int         e;
    int         k;
    logic [7:0] byte_v;
    for (i = 0; i < n_sym; i++) begin
      e = lcg_next() % tab_n;
      for (b = tab_w[e] - 1; b >= 0; b--) begin
        bits_q.push_back(tab_code[e][b]);
      end
    end
    e = lcg_next() % tab_n;
    k = 0;
    while (bits_q.size() % 8 != 0) begin
      bits_q.push_back(tab_code[e][tab_w[e] - 1 - (k % tab_w[e])]);
      k++;
    end
    for (i = 0; i < bits_q.size(); i += 8) begin
      for (b = 0; b < 8; b++) begin
        byte_v[7 - b] = bits_q[i + b];  // msb goes out first
      end
      src_q.push_back(byte_v);
    end
    ref_decode(bits_q);
  endfunction

  task automatic load_table(input int which);
    int i;
    clear_ref();
    tab_n = 0;
    if (which == 0) begin
      // all widths 2 to 5, complete code
      add_entry(8'h41, 5'b00,    2);
      add_entry(8'h7e, 5'b01,    2);
      add_entry(8'h03, 5'b100,   3);
      add_entry(8'hc8, 5'b101,   3);
      add_entry(8'h5a, 5'b1100,  4);
      add_entry(8'h00, 5'b1101,  4);
      add_entry(8'hff, 5'b11100, 5);
      add_entry(8'h92, 5'b11101, 5);
      add_entry(8'h27, 5'b11110, 5);
      add_entry(8'hb4, 5'b11111, 5);
    end else begin
      add_entry(8'h10, 5'b000,   3);  // widths 3 and 5 only
      add_entry(8'h21, 5'b001,   3);
      add_entry(8'h32, 5'b010,   3);
      add_entry(8'h43, 5'b011,   3);
      add_entry(8'h54, 5'b100,   3);
      add_entry(8'h65, 5'b10100, 5);
      add_entry(8'h76, 5'b10111, 5);
      add_entry(8'h87, 5'b11000, 5);
      add_entry(8'h98, 5'b11110, 5);
    end
    for (i = 0; i < tab_n; i++) begin
      ref_valid[tab_w[i]][tab_code[i]] = 1'b1;
      ref_sym[tab_w[i]][tab_code[i]]   = tab_sym[i];
      d_conf  = tab_sym[i];
      h_conf  = huff_pkg::conf_t'(tab_code[i]);
      w_conf  = huff_pkg::conf_t'(tab_w[i]);
      en_conf = 1'b1;
      next_cycle();
      en_conf = 1'b0;
    end
  endtask

  task automatic reset_dut();
    src_q.delete();
    exp_q.delete();
    clear_ref();
    rst = 1'b1;
    repeat (10) next_cycle();
    rst = 1'b0;
    next_cycle();
  endtask

  task automatic drain(input string what);
    while (exp_q.size() != 0) next_cycle();  // timeout process guards this
    repeat (20) next_cycle();                // catch late extra symbols
    check_eq({what, ": bytes left in source"}, src_q.size(), 0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // byte source model
  //////////////////////////////////////////////////////////////////////

  initial begin : byte_source
    int         wait_left;
    int         pause_left;
    logic       busy;
    logic [7:0] held;
    en_in      = 1'b0;
    d_in       = '0;
    ready_in   = 1'b0;
    busy       = 1'b0;
    held       = '0;
    wait_left  = 0;
    pause_left = 0;
    forever begin
      next_cycle();
      en_in = 1'b0;
      if (rst) begin
        busy       = 1'b0;
        pause_left = 0;
      end else begin
        if (d_req) begin
          req_cnt++;
          check_eq("ready_in behind d_req", ready_in, 1'b1);  // value seen at this edge
          if (src_q.size() == 0) begin
            err_cnt++;
            $display("byte source got a request with no byte left at %0t ns", $time);
          end else begin
            held      = src_q.pop_front();
            busy      = 1'b1;
            wait_left = lcg_next() % 3;  // answer 1 to 3 cycles on
          end
        end
        if (busy) begin
          if (wait_left == 0) begin
            en_in = 1'b1;
            d_in  = held;
            busy  = 1'b0;
          end else begin
            wait_left--;
          end
        end
        if (pause_on) begin
          if (pause_left > 0) pause_left--;
          else if (lcg_next() % 8 == 0) pause_left = 3 + lcg_next() % 8;
        end else begin
          pause_left = 0;
        end
      end
      ready_in = (src_q.size() > 0) && (pause_left == 0);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output compare
  //////////////////////////////////////////////////////////////////////

  initial begin : compare_out
    forever begin
      @(posedge clk);
      #1;
      if (en_out === 1'b1) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("output symbol %0h at %0t ns when none was expected", d_out, $time);
        end else begin
          check_eq("decoded symbol", d_out, exp_q.pop_front());
        end
      end
    end
  end

  initial begin : run_limit
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("ERRORS FOUND");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    logic [7:0] rnd_byte;
    rst      = 1'b1;
    d_conf   = '0;
    h_conf   = '0;
    w_conf   = '0;
    en_conf  = 1'b0;
    new_conf = 1'b0;

    // idle after reset, empty table and empty source
    reset_dut();
    repeat (20) begin
      check_eq("d_req while idle", d_req, 1'b0);
      check_eq("en_out while idle", en_out, 1'b0);
      next_cycle();
    end

    // full width table
    reset_dut();
    load_table(0);
    encode_stream(200);
    drain("full table");

    // same again with ready_in drops
    reset_dut();
    load_table(0);
    pause_on = 1'b1;
    encode_stream(200);
    drain("back-pressure");
    pause_on = 1'b0;

    // cleared table takes two bytes and decodes nothing
    reset_dut();
    load_table(0);
    new_conf = 1'b1;
    next_cycle();
    new_conf = 1'b0;
    clear_ref();
    req_cnt = 0;
    repeat (4) begin
      rnd_byte = 8'(lcg_next());
      src_q.push_back(rnd_byte);
    end
    repeat (60) next_cycle();
    check_eq("requests after clear", req_cnt, 2);  // fill 0 and fill 8
    check_eq("bytes left after clear", src_q.size(), 2);

    // widths 3 and 5 only
    reset_dut();
    load_table(1);
    encode_stream(100);
    drain("reconfigured table");

    $display("summary: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* huff_decoder.f */
+incdir+.
huff_pkg.sv
huff_code_group.sv
huff_code_matcher.sv
huff_bit_window.sv
huff_decoder.sv
tb_huff_decoder.sv
